// File: verilog.f
+incdir+.
fletcherPkg.sv
frameCheckPkg.sv
fletcherAccumulator.sv
frameParser.sv
checksumVerdict.sv
frameChecker.sv
frameCheckerTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module frameCheckerTb -f verilog.f -o VframeCheckerTb

./obj_dir/VframeCheckerTb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi

if ! grep -q "TEST PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

echo "Simulation passed"

// File: frameCheckerRef.svh
`ifndef FRAME_CHECKER_REF_SVH
`define FRAME_CHECKER_REF_SVH

typedef logic [15:0] wordQueue_t[$];

//////////////////////////////
// Reference model
//////////////////////////////

// Fletcher-32 by definition, both sums start at 0.
function automatic checksum_t fletcherRef(input wordQueue_t payload);
    int unsigned sumA;
    int unsigned sumB;
    checksum_t   sums;
    sumA = 0;
    sumB = 0;
    foreach (payload[i]) begin
        sumA = (sumA + payload[i]) % 65535;
        sumB = (sumB + sumA) % 65535;
    end
    sums.sumA = sumA[15:0];
    sums.sumB = sumB[15:0];
    return sums;
endfunction

// Header, payload, check A, check B.
function automatic wordQueue_t buildFrame(input wordQueue_t payload, input checksum_t check);
    wordQueue_t frame;
    frame.push_back(16'(payload.size()));
    foreach (payload[i]) begin
        frame.push_back(payload[i]);
    end
    frame.push_back(check.sumA);
    frame.push_back(check.sumB);
    return frame;
endfunction

`endif

// File: frameCheckerTb.sv
`default_nettype none

module frameCheckerTb;
    timeunit 1ns;
    timeprecision 1ns;
    import fletcherPkg::*;
    import frameCheckPkg::*;

    typedef struct packed {
        logic                 valid;
        logic                 last;  // Second check word of a frame.
        logic [wordWidth-1:0] word;
    } streamItem_t;

    typedef struct packed {
        logic      ok;
        checksum_t computed;
    } frameExpect_t;

    logic                  clk;
    logic                  rst;
    logic                  wordValid;
    logic [wordWidth-1:0]  word;
    verdict_t              result;
    logic [countWidth-1:0] goodCount;
    logic [countWidth-1:0] badCount;

    streamItem_t  streamQ[$];
    frameExpect_t expectQ[$];
    int           seed;
    int           totalFrames = 0;
    int           framesDriven = 0;
    int           checkedFrames = 0;
    int           cycleCount = 0;
    int           cycleLimit = 0;

    `include "frameCheckerRef.svh"

    frameChecker u_frameChecker (
        .clk       (clk),
        .rst       (rst),
        .wordValid (wordValid),
        .word      (word),
        .result    (result),
        .goodCount (goodCount),
        .badCount  (badCount)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;  // 100 ns period.

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic stopRun();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
        assert (got === want) else begin
            $display("MISMATCH time=%0t %s expected=%h got=%h", $time, name, want, got);
            stopRun();
        end
    endtask

    // Check words are taken mod 65535, so 16'hFFFF stands for 0.
    function automatic logic checkAccepted(input checksum_t check, input checksum_t sums);
        return (32'(check.sumA) % 65535 == 32'(sums.sumA))
            && (32'(check.sumB) % 65535 == 32'(sums.sumB));
    endfunction

    function automatic wordQueue_t randomPayload(input int length);
        wordQueue_t payload;
        for (int i = 0; i < length; i++) begin
            payload.push_back(16'($random(seed)));
        end
        return payload;
    endfunction

    // Queues the frame words with up to maxGap idle cycles before each.
    task automatic addFrame(input wordQueue_t payload, input checksum_t check, input int maxGap);
        wordQueue_t   frame;
        frameExpect_t expected;
        int           gap;
        expected.computed = fletcherRef(payload);
        expected.ok       = checkAccepted(check, expected.computed);
        frame             = buildFrame(payload, check);
        foreach (frame[i]) begin
            gap = int'($unsigned($random(seed)) % (maxGap + 1));
            repeat (gap) begin
                streamQ.push_back('{valid: 1'b0, last: 1'b0, word: 16'($random(seed))});
            end
            streamQ.push_back('{valid: 1'b1, last: (i == frame.size() - 1), word: frame[i]});
        end
        expectQ.push_back(expected);
        totalFrames++;
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin : stimulus
        wordQueue_t payload;
        checksum_t  check;
        int         length;
        int         bitIndex;
        rst       = 1'b1;
        wordValid = 1'b0;
        word      = '0;
        seed      = 32'h4d66;
        for (int f = 0; f < 6; f++) begin  // Good frames, back to back.
            length  = 1 + int'($unsigned($random(seed)) % 20);
            payload = randomPayload(length);
            addFrame(payload, fletcherRef(payload), 0);
        end
        for (int f = 0; f < 4; f++) begin  // One bit of A or B flipped.
            length   = 1 + int'($unsigned($random(seed)) % 20);
            payload  = randomPayload(length);
            check    = fletcherRef(payload);
            bitIndex = int'($unsigned($random(seed)) % 16);
            if (f % 2 == 0) begin
                check.sumA = check.sumA ^ (16'h1 << bitIndex);
            end else begin
                check.sumB = check.sumB ^ (16'h1 << bitIndex);
            end
            addFrame(payload, check, 0);
        end
        payload = {};
        addFrame(payload, '0, 1);  // Zero length.
        payload = '{16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF};
        addFrame(payload, 32'hFFFF_FFFF, 1);  // Zero written as all ones.
        payload = '{16'hFFFE, 16'hFFFE, 16'h8001, 16'h7FFF, 16'hFFFE};
        addFrame(payload, fletcherRef(payload), 0);
        payload = '{16'h8000, 16'h7FFF, 16'h0001, 16'hFFFE};  // A hits 0 twice.
        addFrame(payload, fletcherRef(payload), 0);
        for (int f = 0; f < 5; f++) begin  // Idle cycles between words.
            length  = 1 + int'($unsigned($random(seed)) % 20);
            payload = randomPayload(length);
            addFrame(payload, fletcherRef(payload), 3);
        end
        cycleLimit = streamQ.size() + 3 * totalFrames + 50;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        foreach (streamQ[i]) begin
            @(posedge clk);
            wordValid <= streamQ[i].valid;
            word      <= streamQ[i].word;
            if (streamQ[i].last) begin
                framesDriven++;
            end
        end
        @(posedge clk);
        wordValid <= 1'b0;
        wait (checkedFrames == totalFrames);
        repeat (2) @(posedge clk);  // No stray result after the last frame.
        $display("TEST PASS");
        $finish;
    end

    //////////////////////////////
    // Compare
    //////////////////////////////

    initial begin : compare
        frameExpect_t          expected;
        logic                  prevValid;
        int                    endedFrames;
        int                    drivenLast;
        logic [countWidth-1:0] goodExpected;
        logic [countWidth-1:0] badExpected;
        prevValid    = 1'b0;
        endedFrames  = 0;
        drivenLast   = 0;
        goodExpected = '0;
        badExpected  = '0;
        forever begin
            @(negedge clk);  // Outputs settle after the rising edge.
            if (!rst) begin
                if (result.valid) begin
                    assert (!prevValid) else begin
                        $display("ERROR: result.valid stayed high for more than one cycle");
                        stopRun();
                    end
                    assert (endedFrames > checkedFrames) else begin
                        $display("ERROR: result.valid pulsed before its frame had ended");
                        stopRun();
                    end
                    expected = expectQ.pop_front();
                    if (expected.ok) begin
                        goodExpected = goodExpected + 16'd1;
                    end else begin
                        badExpected = badExpected + 16'd1;
                    end
                    checkValue("result.ok", 32'(result.ok), 32'(expected.ok));
                    checkValue("result.computed", result.computed, expected.computed);
                    checkValue("goodCount", 32'(goodCount), 32'(goodExpected));
                    checkValue("badCount", 32'(badCount), 32'(badExpected));
                    checkedFrames++;
                end else if (checkedFrames == 0) begin  // Idle after reset.
                    checkValue("goodCount", 32'(goodCount), 32'h0);
                    checkValue("badCount", 32'(badCount), 32'h0);
                end
                prevValid   = result.valid;
                endedFrames = drivenLast;  // Frames past their accept edge.
                drivenLast  = framesDriven;
            end
        end
    end

    // Run limit from the stream length and the per-frame latency.
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            $display("ERROR: timeout after %0d cycles with %0d frames still pending",
                     cycleCount, totalFrames - checkedFrames);
            stopRun();
        end
    end

endmodule

`default_nettype wire

// File: frameChecker.sv
`default_nettype none

module frameChecker (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 wordValid,
    input  logic [fletcherPkg::wordWidth-1:0]    word,
    output frameCheckPkg::verdict_t              result,
    output logic [frameCheckPkg::countWidth-1:0] goodCount,
    output logic [frameCheckPkg::countWidth-1:0] badCount
);
    import fletcherPkg::*;
    import frameCheckPkg::*;

    logic                 sumClear;
    logic                 sumEn;
    logic [wordWidth-1:0] sumDin;
    checksum_t            sums;      // Raw, not yet folded.
    frameEnd_t            frameEnd;

    //////////////////////////////
    // Parser
    //////////////////////////////

    frameParser u_frameParser (
        .clk       (clk),
        .rst       (rst),
        .wordValid (wordValid),
        .word      (word),
        .sumClear  (sumClear),
        .sumEn     (sumEn),
        .sumDin    (sumDin),
        .frameEnd  (frameEnd)
    );

    //////////////////////////////
    // Sums
    //////////////////////////////

    fletcherAccumulator u_fletcherAccumulator (
        .clk      (clk),
        .rst      (rst),
        .sumClear (sumClear),
        .sumEn    (sumEn),
        .sumDin   (sumDin),
        .sums     (sums)
    );

    //////////////////////////////
    // Verdict
    //////////////////////////////

    checksumVerdict u_checksumVerdict (
        .clk       (clk),
        .rst       (rst),
        .frameEnd  (frameEnd),
        .sums      (sums),
        .result    (result),
        .goodCount (goodCount),
        .badCount  (badCount)
    );

endmodule

`default_nettype wire

// File: checksumVerdict.sv
`default_nettype none

module checksumVerdict (
    input  logic                                 clk,
    input  logic                                 rst,
    input  frameCheckPkg::frameEnd_t             frameEnd,
    input  fletcherPkg::checksum_t               sums,
    output frameCheckPkg::verdict_t              result,
    output logic [frameCheckPkg::countWidth-1:0] goodCount,
    output logic [frameCheckPkg::countWidth-1:0] badCount
);
    import fletcherPkg::*;
    import frameCheckPkg::*;

    checksum_t computedNow;
    checksum_t expectedNow;
    logic      match;
    logic      resultValid;
    logic      resultOk;
    checksum_t resultSums;

    //////////////////////////////
    // Fold and compare
    //////////////////////////////

    always_comb begin
        computedNow.sumA = fold(sums.sumA);
        computedNow.sumB = fold(sums.sumB);
        expectedNow.sumA = fold(frameEnd.expected.sumA);  // 16'hFFFF means 0.
        expectedNow.sumB = fold(frameEnd.expected.sumB);
        match            = (computedNow == expectedNow);
    end

    //////////////////////////////
    // Verdict and counters
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
            goodCount   <= '0;
            badCount    <= '0;
        end else begin
            resultValid <= frameEnd.done;
            if (frameEnd.done) begin
                if (match) begin
                    goodCount <= goodCount + 1'b1;  // Wraps.
                end else begin
                    badCount <= badCount + 1'b1;
                end
            end
        end
    end

    // Held until the next frame ends.
    always_ff @(posedge clk) begin
        if (frameEnd.done) begin
            resultOk   <= match;
            resultSums <= computedNow;
        end
    end

    assign result.valid    = resultValid;
    assign result.ok       = resultOk;
    assign result.computed = resultSums;

endmodule

`default_nettype wire

// File: frameParser.sv
`default_nettype none

module frameParser (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              wordValid,
    input  logic [fletcherPkg::wordWidth-1:0] word,
    output logic                              sumClear,
    output logic                              sumEn,
    output logic [fletcherPkg::wordWidth-1:0] sumDin,
    output frameCheckPkg::frameEnd_t          frameEnd
);
    import fletcherPkg::*;
    import frameCheckPkg::*;

    parserState_t         state;
    logic [wordWidth-1:0] remaining;  // Payload words still to come.
    logic                 endStrobe;
    checksum_t            expected;

    //////////////////////////////
    // Frame state machine
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= Idle;
            remaining <= '0;
            sumClear  <= 1'b0;
            sumEn     <= 1'b0;
            endStrobe <= 1'b0;
        end else begin
            sumClear  <= 1'b0;
            sumEn     <= 1'b0;
            endStrobe <= 1'b0;
            if (wordValid) begin
                case (state)
                    Idle: begin
                        remaining <= word;
                        sumClear  <= 1'b1;  // Lands after the previous verdict.
                        if (word == '0) begin
                            state <= CheckA;
                        end else begin
                            state <= Payload;
                        end
                    end
                    Payload: begin
                        sumEn     <= 1'b1;
                        remaining <= remaining - 1'b1;
                        if (remaining == {{(wordWidth-1){1'b0}}, 1'b1}) begin
                            state <= CheckA;
                        end
                    end
                    CheckA: begin
                        state <= CheckB;
                    end
                    CheckB: begin
                        endStrobe <= 1'b1;  // Sums are final by now.
                        state     <= Idle;
                    end
                    default: begin
                        state <= Idle;
                    end
                endcase
            end
        end
    end

    //////////////////////////////
    // Data path
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (wordValid) begin
            if (state == Payload) begin
                sumDin <= word;
            end
            if (state == CheckA) begin
                expected.sumA <= word;
            end
            if (state == CheckB) begin
                expected.sumB <= word;
            end
        end
    end

    assign frameEnd.done     = endStrobe;
    assign frameEnd.expected = expected;

endmodule

`default_nettype wire

// File: fletcherAccumulator.sv
`default_nettype none

module fletcherAccumulator (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              sumClear,
    input  logic                              sumEn,
    input  logic [fletcherPkg::wordWidth-1:0] sumDin,
    output fletcherPkg::checksum_t            sums
);
    import fletcherPkg::*;

    logic [wordWidth-1:0] accA;
    logic [wordWidth-1:0] accB;
    logic [wordWidth-1:0] nextA;
    logic [wordWidth-1:0] nextB;
    logic                 enDelay;  // Sum B trails sum A by one cycle.

    //////////////////////////////
    // Next values
    //////////////////////////////

    // Incremental reduction, no divider in the path.
    assign nextA = onesAdd(accA, sumDin);
    assign nextB = onesAdd(accB, accA);  // A already holds this word.

    //////////////////////////////
    // Two-stage accumulator
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || sumClear) begin
            accA    <= '0;
            accB    <= '0;
            enDelay <= 1'b0;
        end else begin
            enDelay <= sumEn;
            if (sumEn) begin
                accA <= nextA;
            end
            if (enDelay) begin
                accB <= nextB;
            end
        end
    end

    // Raw sums, the all-ones form of zero is left in.
    assign sums.sumA = accA;
    assign sums.sumB = accB;

endmodule

`default_nettype wire

// File: frameCheckPkg.sv
`default_nettype none

package frameCheckPkg;

    //////////////////////////////
    // Frame parsing
    //////////////////////////////

    localparam int countWidth = 16;  // Good and bad frame counters.

    // Header first, then payload, then the two check words.
    typedef enum logic [1:0] {
        Idle,
        Payload,
        CheckA,
        CheckB
    } parserState_t;

    // Frame end strobe together with the check words from the stream.
    typedef struct packed {
        logic                   done;
        fletcherPkg::checksum_t expected;
    } frameEnd_t;

    //////////////////////////////
    // Result
    //////////////////////////////

    // One verdict per frame; ok and computed hold until the next one.
    typedef struct packed {
        logic                   valid;
        logic                   ok;
        fletcherPkg::checksum_t computed;
    } verdict_t;

endpackage

`default_nettype wire

// File: fletcherPkg.sv
`default_nettype none

package fletcherPkg;

    //////////////////////////////
    // Widths and modulus
    //////////////////////////////

    localparam int wordWidth = 16;                            // Word and half-sum width.
    localparam logic [wordWidth-1:0] sumModulus = 16'd65535;  // All ones, same class as 0.

    // Sum B in the upper half, sum A in the lower half.
    typedef struct packed {
        logic [wordWidth-1:0] sumB;
        logic [wordWidth-1:0] sumA;
    } checksum_t;

    //////////////////////////////
    // Modular arithmetic
    //////////////////////////////

    // End-around carry add, which is addition mod 65535.
    // The low half is at most 16'hFFFE when the carry is set, so one pass is enough.
    function automatic logic [wordWidth-1:0] onesAdd(
        input logic [wordWidth-1:0] a,
        input logic [wordWidth-1:0] b
    );
        logic [wordWidth:0] total;
        total = {1'b0, a} + {1'b0, b};
        return total[wordWidth-1:0] + {{(wordWidth-1){1'b0}}, total[wordWidth]};
    endfunction

    // Map the all-ones zero onto the canonical zero.
    function automatic logic [wordWidth-1:0] fold(
        input logic [wordWidth-1:0] value
    );
        return (value == sumModulus) ? '0 : value;
    endfunction

endpackage

`default_nettype wire
